// ==== list.f ====
rtl/tlcs_arch_pkg.sv
rtl/tlcs_uop_pkg.sv
rtl/reg_store.sv
rtl/operand_sel.sv
rtl/alu.sv
rtl/flag_unit.sv
rtl/exec_seq.sv
rtl/tlcs_datapath.sv
test/tb_tlcs_datapath.sv

// ==== rtl/alu.sv ====
// size-aware arithmetic and logic unit
`timescale 1ns/10ps

module alu (
    input  tlcs_uop_pkg::alu_op_e op,
    input  tlcs_arch_pkg::size_e  size,
    input  tlcs_arch_pkg::data_t  a,
    input  tlcs_arch_pkg::data_t  b,
    input  logic                  cin,
    output tlcs_arch_pkg::data_t  result,
    output tlcs_arch_pkg::flags_t flags
);

    tlcs_arch_pkg::data_t mask;
    tlcs_arch_pkg::data_t am;
    tlcs_arch_pkg::data_t bm;
    tlcs_arch_pkg::data_t res;
    logic [32:0]          sum;
    logic [32:0]          diff;
    logic [32:0]          wide;
    logic                 c_eff;
    logic                 is_sub;
    logic                 arith;
    logic                 cy;
    logic                 top_a;
    logic                 top_b;
    logic                 top_r;

    always_comb begin
        case (size)
            tlcs_arch_pkg::SZ_BYTE: mask = 32'h0000_00ff;
            tlcs_arch_pkg::SZ_WORD: mask = 32'h0000_ffff;
            default:                mask = 32'hffff_ffff;
        endcase
    end

    assign am    = a & mask;
    assign bm    = b & mask;
    assign c_eff = cin && (op == tlcs_uop_pkg::OP_ADC || op == tlcs_uop_pkg::OP_SBC);
    assign sum   = {1'b0, am} + {1'b0, bm} + {32'd0, c_eff};
    assign diff  = {1'b0, am} - {1'b0, bm} - {32'd0, c_eff};   // borrow shows above the size

    always_comb begin
        is_sub = 1'b0;
        arith  = 1'b1;
        case (op)
            tlcs_uop_pkg::OP_ADD, tlcs_uop_pkg::OP_ADC: res = sum[31:0];
            tlcs_uop_pkg::OP_SUB, tlcs_uop_pkg::OP_SBC, tlcs_uop_pkg::OP_CP: begin
                res    = diff[31:0];
                is_sub = 1'b1;
            end
            default: begin
                arith = 1'b0;
                case (op)
                    tlcs_uop_pkg::OP_LD:  res = bm;
                    tlcs_uop_pkg::OP_AND: res = am & bm;
                    tlcs_uop_pkg::OP_OR:  res = am | bm;
                    tlcs_uop_pkg::OP_XOR: res = am ^ bm;
                    default:              res = '0;       // setrfp, exf
                endcase
            end
        endcase
        res  = res & mask;
        wide = is_sub ? diff : sum;
        case (size)
            tlcs_arch_pkg::SZ_BYTE: {cy, top_a, top_b, top_r} = {wide[8], am[7], bm[7], res[7]};
            tlcs_arch_pkg::SZ_WORD: begin
                {cy, top_a, top_b, top_r} = {wide[16], am[15], bm[15], res[15]};
            end
            default: {cy, top_a, top_b, top_r} = {wide[32], am[31], bm[31], res[31]};
        endcase
        flags.s = top_r;
        flags.z = (res == '0);
        if (arith) begin
            flags.h = am[4] ^ bm[4] ^ res[4];                       // carry into bit 4
            flags.v = is_sub ? (top_a != top_b) && (top_r != top_a)
                             : (top_a == top_b) && (top_r != top_a);
            flags.n = is_sub;
            flags.c = cy;
        end else begin
            flags.h = (op == tlcs_uop_pkg::OP_AND);
            flags.v = ~^res;                                        // even parity
            flags.n = 1'b0;
            flags.c = 1'b0;
        end
    end

    assign result = res;

endmodule

// ==== rtl/exec_seq.sv ====
// command sequencer
`timescale 1ns/10ps

module exec_seq (
    input  logic                      clk,
    input  logic                      rst,
    input  tlcs_uop_pkg::cmd_t        cmd,
    input  logic                      cmd_valid,
    output logic                      cmd_ready,
    output tlcs_uop_pkg::rsp_t        rsp,
    output logic                      rsp_valid,
    input  logic                      rsp_ready,
    output tlcs_arch_pkg::reg_code_t  src_code,
    output tlcs_arch_pkg::reg_code_t  dst_code,
    output tlcs_arch_pkg::size_e      size,
    input  logic                      src_bad,
    input  logic                      dst_bad,
    input  tlcs_arch_pkg::data_t      src_val,
    input  tlcs_arch_pkg::data_t      dst_val,
    output tlcs_uop_pkg::alu_op_e     alu_op,
    output tlcs_arch_pkg::data_t      op0,
    output tlcs_arch_pkg::data_t      op1,
    input  tlcs_arch_pkg::data_t      alu_res,
    input  tlcs_arch_pkg::flags_t     alu_flags,
    input  tlcs_arch_pkg::flags_t     flags,
    output logic                      wr_en,
    output logic                      rfp_ld,
    output tlcs_arch_pkg::bank_t      rfp_in,
    output tlcs_uop_pkg::flag_class_e upd,
    output logic                      swap,
    input  tlcs_arch_pkg::bank_t      rfp
);

    tlcs_uop_pkg::seq_state_e state;
    tlcs_uop_pkg::cmd_t       cmd_q;
    tlcs_arch_pkg::data_t     data_q;
    logic                     err_q;

    // a pending response blocks new commands unless it leaves now
    assign cmd_ready = (state == tlcs_uop_pkg::ST_IDLE) && (!rsp_valid || rsp_ready);
    assign src_code  = cmd_q.src;
    assign dst_code  = cmd_q.dst;
    assign size      = cmd_q.size;
    assign alu_op    = cmd_q.op;
    assign rfp_in    = cmd_q.imm[1:0];

    // flags and rfp only change in ST_EXEC, so they are held with the data
    assign rsp = '{data: data_q, flags: flags, rfp: rfp, err: err_q};

    always_comb begin
        wr_en  = 1'b0;
        rfp_ld = 1'b0;
        swap   = 1'b0;
        upd    = tlcs_uop_pkg::FC_NONE;
        if (state == tlcs_uop_pkg::ST_EXEC && !err_q) begin
            case (cmd_q.op)
                tlcs_uop_pkg::OP_LD: wr_en = 1'b1;
                tlcs_uop_pkg::OP_ADD, tlcs_uop_pkg::OP_ADC,
                tlcs_uop_pkg::OP_SUB, tlcs_uop_pkg::OP_SBC: begin
                    wr_en = 1'b1;
                    upd   = tlcs_uop_pkg::FC_ARITH;
                end
                tlcs_uop_pkg::OP_CP: upd = tlcs_uop_pkg::FC_ARITH;   // flags only
                tlcs_uop_pkg::OP_AND, tlcs_uop_pkg::OP_OR, tlcs_uop_pkg::OP_XOR: begin
                    wr_en = 1'b1;
                    upd   = tlcs_uop_pkg::FC_LOGIC;
                end
                tlcs_uop_pkg::OP_SETRFP: rfp_ld = 1'b1;
                tlcs_uop_pkg::OP_EXF:    swap   = 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state     <= tlcs_uop_pkg::ST_IDLE;
            rsp_valid <= 1'b0;
            err_q     <= 1'b0;
        end else begin
            case (state)
                tlcs_uop_pkg::ST_IDLE: begin
                    if (rsp_valid && rsp_ready)
                        rsp_valid <= 1'b0;
                    else if (rsp_valid)
                        state <= tlcs_uop_pkg::ST_RESP;      // back-pressure
                    if (cmd_valid && cmd_ready)
                        state <= tlcs_uop_pkg::ST_READ;
                end
                tlcs_uop_pkg::ST_READ: begin
                    err_q <= dst_bad || (src_bad && !cmd_q.use_imm);
                    state <= tlcs_uop_pkg::ST_EXEC;
                end
                tlcs_uop_pkg::ST_EXEC: begin
                    rsp_valid <= 1'b1;
                    state     <= tlcs_uop_pkg::ST_IDLE;
                end
                default: begin
                    if (rsp_ready) begin
                        rsp_valid <= 1'b0;
                        state     <= tlcs_uop_pkg::ST_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_valid && cmd_ready)
            cmd_q <= cmd;
        if (state == tlcs_uop_pkg::ST_READ) begin
            op0 <= dst_val;
            op1 <= cmd_q.use_imm ? cmd_q.imm : src_val;
        end
        if (state == tlcs_uop_pkg::ST_EXEC)
            data_q <= err_q ? '0 : alu_res;
    end

    a_rsp_hold: assert property (@(posedge clk) disable iff (rst)
                                 rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
        else $error("response changed under back-pressure");

    // the flag unit takes the ALU flags one edge after an update request
    a_flag_load: assert property (@(posedge clk) disable iff (rst)
                                  upd != tlcs_uop_pkg::FC_NONE |=> flags == $past(alu_flags))
        else $error("main flags differ from the ALU flags after an update");

endmodule

// ==== rtl/flag_unit.sv ====
// main and alternate flag sets
`timescale 1ns/10ps

module flag_unit (
    input  logic                      clk,
    input  logic                      rst,
    input  tlcs_uop_pkg::flag_class_e upd,
    input  tlcs_arch_pkg::flags_t     fin,
    input  logic                      swap,
    output tlcs_arch_pkg::flags_t     flags
);

    tlcs_arch_pkg::flags_t main_f;
    tlcs_arch_pkg::flags_t alt_f;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            main_f <= '0;
            alt_f  <= '0;
        end else if (swap) begin
            main_f <= alt_f;          // exf
            alt_f  <= main_f;
        end else begin
            case (upd)
                tlcs_uop_pkg::FC_ARITH, tlcs_uop_pkg::FC_LOGIC: main_f <= fin;
                default: ;
            endcase
        end
    end

    assign flags = main_f;

    // a swap and a flag update come from different instructions
    a_swap_upd_excl: assert property (@(posedge clk) disable iff (rst)
                                      !(swap && upd != tlcs_uop_pkg::FC_NONE))
        else $error("flag swap and flag update in the same cycle");

endmodule

// ==== rtl/operand_sel.sv ====
// register code decoder
`timescale 1ns/10ps

module operand_sel (
    input  tlcs_arch_pkg::reg_code_t code,
    input  tlcs_arch_pkg::size_e     size,
    input  tlcs_arch_pkg::bank_t     rfp,
    output tlcs_arch_pkg::reg_loc_t  loc,
    output logic                     bad
);

    tlcs_arch_pkg::bank_t prev_bank;

    assign prev_bank = rfp - 2'd1;    // wraps from bank 0 to bank 3

    always_comb begin
        loc      = '0;
        bad      = 1'b0;
        loc.lane = code[1:0];
        casez (code)
            8'b00??_????: loc.index = code[5:2];              // direct bank register
            8'b1101_????: loc.index = {prev_bank, code[3:2]};
            8'b1110_????: loc.index = {rfp, code[3:2]};
            8'b1111_????: begin
                loc.is_ptr = 1'b1;
                loc.index  = {2'b00, code[3:2]};
            end
            default:      bad = 1'b1;
        endcase
        // alignment for the access size
        case (size)
            tlcs_arch_pkg::SZ_WORD: begin
                if (code[0])
                    bad = 1'b1;
            end
            tlcs_arch_pkg::SZ_LONG: begin
                if (code[1:0] != 2'b00)
                    bad = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

// ==== rtl/reg_store.sv ====
// banked register file
`timescale 1ns/10ps

module reg_store (
    input  logic                    clk,
    input  logic                    rst,
    input  tlcs_arch_pkg::reg_loc_t rd_src,
    input  tlcs_arch_pkg::reg_loc_t rd_dst,
    output tlcs_arch_pkg::data_t    src_val,
    output tlcs_arch_pkg::data_t    dst_val,
    input  logic                    wr_en,
    input  tlcs_arch_pkg::reg_loc_t wr_loc,
    input  tlcs_arch_pkg::size_e    wr_size,   // size of the instruction in flight
    input  tlcs_arch_pkg::data_t    wr_data,
    input  logic                    rfp_ld,
    input  tlcs_arch_pkg::bank_t    rfp_in,
    output tlcs_arch_pkg::bank_t    rfp
);

    tlcs_arch_pkg::data_t accs [tlcs_arch_pkg::NUM_ACCS];
    tlcs_arch_pkg::data_t ptrs [tlcs_arch_pkg::NUM_PTRS];
    tlcs_arch_pkg::data_t src_word;
    tlcs_arch_pkg::data_t dst_word;
    tlcs_arch_pkg::data_t wr_word;
    logic [3:0]           wr_mask;

    // shift the addressed lane down, then cut to the size
    function automatic tlcs_arch_pkg::data_t extract(tlcs_arch_pkg::data_t word,
                                                     tlcs_arch_pkg::lane_t lane,
                                                     tlcs_arch_pkg::size_e sz);
        tlcs_arch_pkg::data_t shifted;
        shifted = word >> {lane, 3'b000};
        case (sz)
            tlcs_arch_pkg::SZ_BYTE: return {24'h0, shifted[7:0]};
            tlcs_arch_pkg::SZ_WORD: return {16'h0, shifted[15:0]};
            default:                return shifted;
        endcase
    endfunction

    assign src_word = rd_src.is_ptr ? ptrs[rd_src.index[1:0]] : accs[rd_src.index];
    assign dst_word = rd_dst.is_ptr ? ptrs[rd_dst.index[1:0]] : accs[rd_dst.index];
    assign src_val  = extract(src_word, rd_src.lane, wr_size);
    assign dst_val  = extract(dst_word, rd_dst.lane, wr_size);

    always_comb begin
        case (wr_size)
            tlcs_arch_pkg::SZ_BYTE: wr_mask = 4'b0001 << wr_loc.lane;
            tlcs_arch_pkg::SZ_WORD: wr_mask = 4'b0011 << wr_loc.lane;
            default:                wr_mask = 4'b1111;
        endcase
    end

    assign wr_word = wr_data << {wr_loc.lane, 3'b000};   // align result to lane

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            for (int i = 0; i < tlcs_arch_pkg::NUM_ACCS; i++) begin
                accs[i] <= '0;
            end
            for (int j = 0; j < tlcs_arch_pkg::NUM_PTRS; j++) begin
                ptrs[j] <= '0;
            end
            rfp <= '0;
        end else begin
            if (wr_en) begin
                for (int k = 0; k < 4; k++) begin
                    if (wr_mask[k]) begin              // untouched lanes keep their bytes
                        if (wr_loc.is_ptr)
                            ptrs[wr_loc.index[1:0]][8*k +: 8] <= wr_word[8*k +: 8];
                        else
                            accs[wr_loc.index][8*k +: 8] <= wr_word[8*k +: 8];
                    end
                end
            end
            if (rfp_ld) begin
                rfp <= rfp_in;
            end
        end
    end

    // the sequencer never writes a register and the bank pointer together
    a_wr_rfp_excl: assert property (@(posedge clk) disable iff (rst) !(wr_en && rfp_ld))
        else $error("register write and rfp load in the same cycle");

endmodule

// ==== rtl/tlcs_arch_pkg.sv ====
// register set architecture
package tlcs_arch_pkg;

    localparam int NUM_ACCS = 16;     // four banks of four
    localparam int NUM_PTRS = 4;      // xix, xiy, xiz, xsp

    typedef logic [31:0] data_t;
    typedef logic [7:0]  reg_code_t;
    typedef logic [1:0]  bank_t;      // register file pointer width
    typedef logic [1:0]  lane_t;      // byte lane in a 32-bit register

    typedef enum logic [1:0] {
        SZ_BYTE,
        SZ_WORD,
        SZ_LONG
    } size_e;

    // decoded register location
    typedef struct packed {
        logic       is_ptr;
        logic [3:0] index;            // {bank, reg} or pointer in [1:0]
        lane_t      lane;
    } reg_loc_t;

    typedef struct packed {
        logic s;
        logic z;
        logic h;
        logic v;                      // overflow or parity
        logic n;
        logic c;
    } flags_t;

endpackage

// ==== rtl/tlcs_datapath.sv ====
// register and flag datapath top
`timescale 1ns/10ps

module tlcs_datapath (
    input  logic               clk,
    input  logic               rst,
    input  tlcs_uop_pkg::cmd_t cmd,
    input  logic               cmd_valid,
    output logic               cmd_ready,
    output tlcs_uop_pkg::rsp_t rsp,
    output logic               rsp_valid,
    input  logic               rsp_ready
);

    tlcs_arch_pkg::reg_code_t  src_code;
    tlcs_arch_pkg::reg_code_t  dst_code;
    tlcs_arch_pkg::size_e      size;
    tlcs_arch_pkg::reg_loc_t   src_loc;
    tlcs_arch_pkg::reg_loc_t   dst_loc;
    logic                      src_bad;
    logic                      dst_bad;
    tlcs_arch_pkg::data_t      src_val;
    tlcs_arch_pkg::data_t      dst_val;
    tlcs_uop_pkg::alu_op_e     alu_op;
    tlcs_arch_pkg::data_t      op0;
    tlcs_arch_pkg::data_t      op1;
    tlcs_arch_pkg::data_t      alu_res;
    tlcs_arch_pkg::flags_t     alu_flags;
    tlcs_arch_pkg::flags_t     flags;
    logic                      wr_en;
    logic                      rfp_ld;
    tlcs_arch_pkg::bank_t      rfp_in;
    tlcs_arch_pkg::bank_t      rfp;
    tlcs_uop_pkg::flag_class_e upd;
    logic                      swap;

    exec_seq u_seq (
        .clk, .rst, .cmd, .cmd_valid, .cmd_ready, .rsp, .rsp_valid, .rsp_ready,
        .src_code, .dst_code, .size, .src_bad, .dst_bad, .src_val, .dst_val,
        .alu_op, .op0, .op1, .alu_res, .alu_flags, .flags,
        .wr_en, .rfp_ld, .rfp_in, .upd, .swap, .rfp
    );

    operand_sel u_src_sel (.code(src_code), .size, .rfp, .loc(src_loc), .bad(src_bad));
    operand_sel u_dst_sel (.code(dst_code), .size, .rfp, .loc(dst_loc), .bad(dst_bad));

    reg_store u_regs (
        .clk, .rst, .rd_src(src_loc), .rd_dst(dst_loc), .src_val, .dst_val,
        .wr_en, .wr_loc(dst_loc), .wr_size(size), .wr_data(alu_res),
        .rfp_ld, .rfp_in, .rfp
    );

    alu u_alu (
        .op(alu_op), .size, .a(op0), .b(op1), .cin(flags.c),   // carry from main flags
        .result(alu_res), .flags(alu_flags)
    );

    flag_unit u_flags (.clk, .rst, .upd, .fin(alu_flags), .swap, .flags);

endmodule

// ==== rtl/tlcs_uop_pkg.sv ====
// micro-instruction layer types
package tlcs_uop_pkg;

    typedef enum logic [3:0] {
        OP_LD,
        OP_ADD,
        OP_ADC,
        OP_SUB,
        OP_SBC,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_CP,
        OP_SETRFP,
        OP_EXF
    } alu_op_e;

    typedef struct packed {
        alu_op_e                  op;
        tlcs_arch_pkg::size_e     size;
        tlcs_arch_pkg::reg_code_t dst;
        tlcs_arch_pkg::reg_code_t src;
        logic                     use_imm;   // op1 from imm, src ignored
        tlcs_arch_pkg::data_t     imm;
    } cmd_t;

    typedef struct packed {
        tlcs_arch_pkg::data_t  data;
        tlcs_arch_pkg::flags_t flags;
        tlcs_arch_pkg::bank_t  rfp;
        logic                  err;
    } rsp_t;

    typedef enum logic [1:0] {
        FC_NONE,
        FC_ARITH,
        FC_LOGIC
    } flag_class_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_READ,
        ST_EXEC,
        ST_RESP
    } seq_state_e;

endpackage

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_tlcs_datapath -f list.f -o tb_sim

./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log

grep -q "All tests passed" sim.log
echo "simulation passed"

// ==== test/tb_tlcs_datapath.sv ====
// datapath testbench
`timescale 1ns/10ps

module tb_tlcs_datapath;

    logic               clk;
    logic               rst;
    tlcs_uop_pkg::cmd_t cmd;
    logic               cmd_valid;
    logic               cmd_ready;
    tlcs_uop_pkg::rsp_t rsp;
    logic               rsp_valid;
    logic               rsp_ready;

    integer                seed;
    int                    n_issued;
    int                    wd_cycles;
    logic                  stall_en;       // random rsp_ready back-pressure
    tlcs_arch_pkg::data_t  m_regs [20];    // 16 bank registers, then 4 pointers
    tlcs_arch_pkg::bank_t  m_rfp;
    tlcs_arch_pkg::flags_t m_main;
    tlcs_arch_pkg::flags_t m_alt;

    tlcs_uop_pkg::alu_op_e arith_ops [5] = '{tlcs_uop_pkg::OP_ADD, tlcs_uop_pkg::OP_ADC,
        tlcs_uop_pkg::OP_SUB, tlcs_uop_pkg::OP_SBC, tlcs_uop_pkg::OP_CP};
    tlcs_uop_pkg::alu_op_e logic_ops [3] = '{tlcs_uop_pkg::OP_AND, tlcs_uop_pkg::OP_OR,
        tlcs_uop_pkg::OP_XOR};

    tlcs_datapath DUT (.clk, .rst, .cmd, .cmd_valid, .cmd_ready, .rsp, .rsp_valid, .rsp_ready);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_data(input string name, input tlcs_arch_pkg::data_t exp,
                              input tlcs_arch_pkg::data_t act);
        if (act !== exp)
            stop_run($sformatf("** Error %s data: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_flags(input string name, input tlcs_arch_pkg::flags_t exp,
                               input tlcs_arch_pkg::flags_t act);
        if (act !== exp)
            stop_run($sformatf("** Error %s flags szhvnc: expected %b, actual %b",
                               name, exp, act));
    endtask

    task automatic check_rfp(input string name, input tlcs_arch_pkg::bank_t exp,
                             input tlcs_arch_pkg::bank_t act);
        if (act !== exp)
            stop_run($sformatf("** Error %s rfp: expected %0d, actual %0d", name, exp, act));
    endtask

    task automatic check_err(input string name, input logic exp, input logic act);
        if (act !== exp)
            stop_run($sformatf("** Error %s err: expected %b, actual %b", name, exp, act));
    endtask

    // random legal code, aligned for the size
    function automatic tlcs_arch_pkg::reg_code_t pick_code(input tlcs_arch_pkg::size_e sz);
        logic [1:0] kind;
        logic [1:0] reg_n;
        logic [1:0] lane;
        kind  = 2'($random(seed));
        reg_n = 2'($random(seed));
        if (sz == tlcs_arch_pkg::SZ_BYTE)
            lane = 2'($random(seed));
        else if (sz == tlcs_arch_pkg::SZ_WORD)
            lane = {1'($random(seed)), 1'b0};
        else
            lane = 2'b00;
        case (kind)
            2'd0:    return {2'b00, 2'($random(seed)), reg_n, lane};   // direct
            2'd1:    return {4'hd, reg_n, lane};
            2'd2:    return {4'he, reg_n, lane};
            default: return {4'hf, reg_n, lane};
        endcase
    endfunction

    function automatic tlcs_uop_pkg::cmd_t make_cmd(input tlcs_uop_pkg::alu_op_e op,
        input tlcs_arch_pkg::size_e sz, input tlcs_arch_pkg::reg_code_t dst,
        input tlcs_arch_pkg::reg_code_t src, input logic use_imm,
        input tlcs_arch_pkg::data_t imm);
        return '{op: op, size: sz, dst: dst, src: src, use_imm: use_imm, imm: imm};
    endfunction

    function automatic tlcs_arch_pkg::size_e rand_size();
        return tlcs_arch_pkg::size_e'($unsigned($random(seed)) % 3);
    endfunction

    // two's complement value of the low width bits
    function automatic longint signed_value(input logic [63:0] x, input int width);
        return x[width-1] ? longint'(x) - (longint'(1) << width) : longint'(x);
    endfunction

    // model slot of a code
    task automatic locate(input tlcs_arch_pkg::reg_code_t code, input tlcs_arch_pkg::size_e sz,
                          output int slot, output logic bad);
        int prev;
        prev = (int'(m_rfp) + 3) % 4;                   // bank below rfp
        bad  = 1'b0;
        slot = 0;
        if (code < 8'h40)
            slot = int'(code) / 4;
        else if (code[7:4] == 4'hd)
            slot = 4 * prev + int'(code[3:2]);
        else if (code[7:4] == 4'he)
            slot = 4 * int'(m_rfp) + int'(code[3:2]);
        else if (code[7:4] == 4'hf)
            slot = 16 + int'(code[3:2]);
        else
            bad = 1'b1;
        if (sz == tlcs_arch_pkg::SZ_WORD && code[0])
            bad = 1'b1;
        if (sz == tlcs_arch_pkg::SZ_LONG && code[1:0] != 2'b00)
            bad = 1'b1;
    endtask

    // reference model: updates the state and returns the expected response
    task automatic predict(input tlcs_uop_pkg::cmd_t c, output tlcs_uop_pkg::rsp_t exp);
        int                    width;
        int                    dslot;
        int                    sslot;
        int                    sh;
        logic                  dbad;
        logic                  sbad;
        logic                  err;
        logic                  cin;
        logic                  is_add;
        logic                  is_sub;
        logic [63:0]           mask;
        logic [63:0]           a;
        logic [63:0]           b;
        logic [63:0]           full;
        logic [63:0]           res;
        longint                sres;
        longint                lim;
        tlcs_arch_pkg::flags_t f;
        width  = (c.size == tlcs_arch_pkg::SZ_BYTE) ? 8 :
                 (c.size == tlcs_arch_pkg::SZ_WORD) ? 16 : 32;
        mask   = (64'd1 << width) - 64'd1;
        lim    = longint'(1) << (width - 1);
        locate(c.dst, c.size, dslot, dbad);
        locate(c.src, c.size, sslot, sbad);
        err    = dbad || (sbad && !c.use_imm);
        sh     = 8 * int'(c.dst[1:0]);
        a      = (64'(m_regs[dslot]) >> sh) & mask;
        b      = c.use_imm ? (64'(c.imm) & mask)
                           : ((64'(m_regs[sslot]) >> (8 * int'(c.src[1:0]))) & mask);
        cin    = (c.op == tlcs_uop_pkg::OP_ADC || c.op == tlcs_uop_pkg::OP_SBC) && m_main.c;
        is_add = c.op inside {tlcs_uop_pkg::OP_ADD, tlcs_uop_pkg::OP_ADC};
        is_sub = c.op inside {tlcs_uop_pkg::OP_SUB, tlcs_uop_pkg::OP_SBC, tlcs_uop_pkg::OP_CP};
        f      = '0;
        if (is_add) begin
            full = a + b + 64'(cin);
            res  = full & mask;
            sres = signed_value(a, width) + signed_value(b, width) + longint'(cin);
            f.c  = full[width];
            f.h  = ((a & 15) + (b & 15) + 64'(cin)) > 15;
            f.v  = (sres >= lim) || (sres < -lim);       // signed result out of range
        end else if (is_sub) begin
            res  = (a - b - 64'(cin)) & mask;
            sres = signed_value(a, width) - signed_value(b, width) - longint'(cin);
            f.c  = (b + 64'(cin)) > a;                   // borrow out of the size
            f.h  = ((b & 15) + 64'(cin)) > (a & 15);
            f.v  = (sres >= lim) || (sres < -lim);
            f.n  = 1'b1;
        end else begin
            case (c.op)
                tlcs_uop_pkg::OP_LD:  res = b;
                tlcs_uop_pkg::OP_AND: res = a & b;
                tlcs_uop_pkg::OP_OR:  res = a | b;
                tlcs_uop_pkg::OP_XOR: res = a ^ b;
                default:              res = 64'd0;
            endcase
            f.h = (c.op == tlcs_uop_pkg::OP_AND);
            f.v = ($countones(res) % 2) == 0;            // even parity
        end
        f.s = res[width-1];
        f.z = (res == 64'd0);
        if (!err) begin
            if (is_add || c.op inside {tlcs_uop_pkg::OP_SUB, tlcs_uop_pkg::OP_SBC,
                    tlcs_uop_pkg::OP_LD, tlcs_uop_pkg::OP_AND, tlcs_uop_pkg::OP_OR,
                    tlcs_uop_pkg::OP_XOR})
                m_regs[dslot] = (m_regs[dslot] & ~32'(mask << sh)) | 32'(res << sh);
            if (is_add || is_sub || c.op inside {tlcs_uop_pkg::OP_AND, tlcs_uop_pkg::OP_OR,
                    tlcs_uop_pkg::OP_XOR})
                m_main = f;
            if (c.op == tlcs_uop_pkg::OP_SETRFP)
                m_rfp = c.imm[1:0];
            if (c.op == tlcs_uop_pkg::OP_EXF) begin
                f      = m_main;
                m_main = m_alt;
                m_alt  = f;
            end
        end
        exp.data  = err ? 32'd0 : 32'(res);
        exp.flags = m_main;
        exp.rfp   = m_rfp;
        exp.err   = err;
    endtask

    // one command through the handshake, response checked against the model
    task automatic run_cmd(input tlcs_uop_pkg::cmd_t c, input string name);
        tlcs_uop_pkg::rsp_t exp;
        tlcs_uop_pkg::rsp_t held;
        logic               taken;
        int                 stall;
        predict(c, exp);
        stall = (stall_en && $unsigned($random(seed)) % 2 == 0) ?
                1 + $unsigned($random(seed)) % 6 : 0;
        n_issued++;
        cmd       = c;
        cmd_valid = 1'b1;
        taken     = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = cmd_ready;
            @(posedge clk);
            #1;
        end
        cmd_valid = 1'b0;
        rsp_ready = (stall == 0);
        do
            @(negedge clk);
        while (!rsp_valid);
        check_err(name, exp.err, rsp.err);
        check_data(name, exp.data, rsp.data);
        check_flags(name, exp.flags, rsp.flags);
        check_rfp(name, exp.rfp, rsp.rfp);
        held = rsp;
        repeat (stall) begin
            @(negedge clk);
            if (!rsp_valid || rsp !== held || cmd_ready)
                stop_run($sformatf("%s: response not held while rsp_ready was low", name));
        end
        @(posedge clk);
        #1;
        if (!rsp_ready) begin
            rsp_ready = 1'b1;
            @(posedge clk);                              // response leaves here
            #1;
        end
    endtask

    task automatic read_back(input tlcs_arch_pkg::reg_code_t code, input string name);
        run_cmd(make_cmd(tlcs_uop_pkg::OP_OR, tlcs_arch_pkg::SZ_LONG, code & 8'hfc, 8'h00,
                         1'b1, 32'd0), name);
    endtask

    initial begin
        tlcs_arch_pkg::size_e     sz;
        tlcs_arch_pkg::reg_code_t code;
        tlcs_arch_pkg::bank_t     bank;
        tlcs_arch_pkg::bank_t     prev;
        tlcs_uop_pkg::alu_op_e    op;
        logic [1:0]               reg_a;
        logic [1:0]               reg_b;
        seed      = 27;
        n_issued  = 0;
        stall_en  = 1'b0;
        rst       = 1'b1;
        cmd       = '0;
        cmd_valid = 1'b0;
        rsp_ready = 1'b1;
        for (int i = 0; i < 20; i++)
            m_regs[i] = '0;
        m_rfp  = '0;
        m_main = '0;
        m_alt  = '0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        if (!cmd_ready || rsp_valid)
            stop_run("handshake outputs are wrong after reset");
        repeat (4)
            read_back(pick_code(tlcs_arch_pkg::SZ_LONG), "reset_state");
        repeat (16) begin
            sz   = rand_size();
            code = pick_code(sz);
            run_cmd(make_cmd(tlcs_uop_pkg::OP_LD, sz, code, 8'h00, 1'b1, $random(seed)), "ld");
            read_back(code, "ld_lanes");
        end
        repeat (40) begin
            op   = arith_ops[$unsigned($random(seed)) % 5];
            sz   = rand_size();
            code = pick_code(sz);
            run_cmd(make_cmd(op, sz, code, pick_code(sz), 1'($random(seed)), $random(seed)),
                    "arith");
            if (op == tlcs_uop_pkg::OP_CP)
                read_back(code, "cp_keeps_dst");
        end
        repeat (30) begin
            sz = rand_size();
            if ($unsigned($random(seed)) % 4 == 0)
                run_cmd(make_cmd(tlcs_uop_pkg::OP_EXF, tlcs_arch_pkg::SZ_LONG, 8'h00, 8'h00,
                                 1'b1, 32'd0), "exf");
            else
                run_cmd(make_cmd(logic_ops[$unsigned($random(seed)) % 3], sz, pick_code(sz),
                                 pick_code(sz), 1'($random(seed)), $random(seed)), "logic");
        end
        repeat (8) begin
            bank  = 2'($random(seed));
            prev  = bank - 2'd1;
            reg_a = 2'($random(seed));
            reg_b = 2'($random(seed));
            run_cmd(make_cmd(tlcs_uop_pkg::OP_SETRFP, tlcs_arch_pkg::SZ_LONG, 8'h00, 8'h00,
                             1'b1, {$random(seed)} & 32'hffff_fffc | 32'(bank)), "setrfp");
            run_cmd(make_cmd(tlcs_uop_pkg::OP_LD, tlcs_arch_pkg::SZ_LONG, {4'he, reg_a, 2'b00},
                             8'h00, 1'b1, $random(seed)), "ld_cur_bank");
            run_cmd(make_cmd(tlcs_uop_pkg::OP_LD, tlcs_arch_pkg::SZ_LONG, {4'hd, reg_b, 2'b00},
                             8'h00, 1'b1, $random(seed)), "ld_prev_bank");
            read_back({2'b00, bank, reg_a, 2'b00}, "cur_bank_direct");
            read_back({2'b00, prev, reg_b, 2'b00}, "prev_bank_direct");
        end
        stall_en = 1'b1;
        repeat (30) begin
            op   = arith_ops[$unsigned($random(seed)) % 5];
            sz   = rand_size();
            code = pick_code(sz);
            case ($unsigned($random(seed)) % 5)
                0: run_cmd(make_cmd(op, sz, 8'h40 + 8'($unsigned($random(seed)) % 144),
                                    8'h00, 1'b1, $random(seed)), "illegal_dst");
                1: run_cmd(make_cmd(op, sz, code, 8'h40 + 8'($unsigned($random(seed)) % 144),
                                    1'b0, 32'd0), "illegal_src");
                2: run_cmd(make_cmd(op, tlcs_arch_pkg::SZ_WORD, code | 8'h01, 8'h00, 1'b1,
                                    $random(seed)), "misaligned_word");
                3: run_cmd(make_cmd(op, tlcs_arch_pkg::SZ_LONG, {code[7:2], 2'b00} |
                                    8'(1 + $unsigned($random(seed)) % 3), 8'h00, 1'b1,
                                    $random(seed)), "misaligned_long");
                default: run_cmd(make_cmd(op, sz, code, pick_code(sz), 1'b1, $random(seed)),
                                 "legal_stall");
            endcase
            read_back(code, "state_after_err");
        end
        $display("All tests passed");
        $finish;
    end

    // budget of 20 cycles per issued command
    initial begin
        wd_cycles = 0;
        while (wd_cycles <= 20 * n_issued + 200) begin
            @(posedge clk);
            wd_cycles++;
        end
        stop_run("watchdog expired, the DUT stopped responding");
    end

endmodule
